// ==== bench/hydra_tb_table.svh ====
`ifndef HYDRA_TB_TABLE_SVH
`define HYDRA_TB_TABLE_SVH

localparam int ROWS = 14;

// columns are source port, destination port, length in words and tag
// the destination column is also the port where the packet must come out
localparam int PKT_TABLE [ROWS][4] = '{
    '{0, 1, 4, 'h10},
    '{1, 2, 1, 'h11},
    '{2, 3, 16, 'h12},
    '{3, 0, 7, 'h13},
    '{0, 0, 2, 'h14},
    '{1, 1, 9, 'h15},
    '{2, 2, 3, 'h16},
    '{3, 3, 5, 'h17},
    '{0, 2, 12, 'h18},
    '{1, 3, 1, 'h19},
    '{2, 0, 6, 'h1a},
    '{3, 1, 15, 'h1b},
    '{1, 0, 8, 'h1c},
    '{2, 1, 2, 'h1d}
};

`endif

// ==== bench/hydra_tb.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module hydra_tb;
    import hydra_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    `include "hydra_tb_table.svh"

    logic       clk = 1'b0;
    logic       rst_n;
    port_mask_t wr_sop;
    port_mask_t wr_eop;
    port_mask_t wr_vld;
    word_t      wr_data [`HYDRA_PORTS];
    port_mask_t pause;
    port_mask_t ready;
    port_mask_t rd_sop;
    port_mask_t rd_eop;
    port_mask_t rd_vld;
    word_t      rd_data [`HYDRA_PORTS];
    logic       full;
    logic       almost_full;

    // expected output words per port with sop in bit 17 and eop in bit 16
    logic [17:0] exp_q [`HYDRA_PORTS][$];
    port_mask_t  prev_ready = '1;
    port_mask_t  prev_vld;
    port_mask_t  prev_sop;
    port_mask_t  prev_eop;
    word_t       prev_data [`HYDRA_PORTS];
    logic [31:0] data_rng = 32'hc0df;
    logic [31:0] ready_rng = 32'hc0df;
    // 0 holds every ready low, 1 holds every ready high, 2 draws them at random
    int          ready_mode = 1;
    int          errors = 0;
    int          hold_errors = 0;
    int          stalls_seen = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    hydra_switch i_hydra_switch (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .pause       (pause),
        .ready       (ready),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data),
        .full        (full),
        .almost_full (almost_full)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit queues_empty();
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_word(input int p);
        logic [17:0] want;
        if (exp_q[p].size() == 0) begin
            $display("t=%0t output port %0d delivered word %h that no packet was sent for",
                     $time, p, rd_data[p]);
            errors++;
        end else begin
            want = exp_q[p].pop_front();
            compare_value($sformatf("rd_data[%0d]", p), rd_data[p], want[15:0]);
            compare_value($sformatf("rd_sop[%0d]", p), rd_sop[p], want[17]);
            compare_value($sformatf("rd_eop[%0d]", p), rd_eop[p], want[16]);
        end
    endtask

    // ready is driven and the outputs sampled in one process, so a word counts
    // as moved exactly when both are high before the next rising edge
    always @(negedge clk) begin
        int e0;
        if (rst_n) begin
            e0 = errors;
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if (!prev_ready[p]) begin
                    if (prev_vld[p]) begin
                        stalls_seen++;
                    end
                    compare_value($sformatf("held rd_vld[%0d]", p), rd_vld[p], prev_vld[p]);
                    compare_value($sformatf("held rd_sop[%0d]", p), rd_sop[p], prev_sop[p]);
                    compare_value($sformatf("held rd_eop[%0d]", p), rd_eop[p], prev_eop[p]);
                    compare_value($sformatf("held rd_data[%0d]", p), rd_data[p], prev_data[p]);
                end
            end
            hold_errors += errors - e0;
            ready_rng = lcg_step(ready_rng);
            case (ready_mode)
                0: ready = '0;
                1: ready = '1;
                default: ready = ready_rng[19:16];
            endcase
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if (rd_vld[p] && ready[p]) begin
                    check_word(p);
                end
                prev_data[p] = rd_data[p];
            end
            prev_ready = ready;
            prev_vld = rd_vld;
            prev_sop = rd_sop;
            prev_eop = rd_eop;
        end
    end

    // the header carries the tag in its upper byte and the destination below
    task automatic send_packet(input int src, input int dst, input int len, input int tag,
                               input bit record, output bit ok);
        word_t w;
        int    cnt;
        ok = 1'b1;
        for (int i = 0; i < len && ok; i++) begin
            if (i == 0) begin
                w = word_t'((tag << 8) | dst);
            end else begin
                data_rng = lcg_step(data_rng);
                w = data_rng[31:16];
            end
            if (record) begin
                exp_q[dst].push_back({i == 0, i == len - 1, w});
            end
            wr_data[src] = w;
            wr_vld[src] = 1'b1;
            wr_sop[src] = (i == 0);
            wr_eop[src] = (i == len - 1);
            cnt = 0;
            while (pause[src] && cnt < TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (pause[src]) begin
                ok = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
        wr_vld[src] = 1'b0;
        wr_sop[src] = 1'b0;
        wr_eop[src] = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int cnt;
        cnt = 0;
        while (!queues_empty() && cnt < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!queues_empty()) begin
            $display("t=%0t %s did not all come out before the timeout", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    initial begin
        int err0;
        int cnt;
        bit ok;
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        ready = '0;
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            wr_data[p] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        compare_value("rd_vld", rd_vld, 0);
        compare_value("rd_sop", rd_sop, 0);
        compare_value("rd_eop", rd_eop, 0);
        compare_value("full", full, 0);
        compare_value("almost_full", almost_full, 0);
        compare_value("pause", pause, 4'hf);
        report_test("reset values", err0);

        err0 = errors;
        send_packet(0, 2, 5, 'h5a, 1'b1, ok);
        if (!ok) begin
            $display("t=%0t the single packet was never accepted", $time);
            errors++;
        end
        wait_drain("the single packet");
        report_test("single packet", err0);

        err0 = errors;
        ready_mode = 2;
        for (int r = 0; r < ROWS; r++) begin
            send_packet(PKT_TABLE[r][0], PKT_TABLE[r][1], PKT_TABLE[r][2], PKT_TABLE[r][3],
                        1'b1, ok);
            if (!ok) begin
                $display("t=%0t table row %0d was never accepted", $time, r);
                errors++;
            end
        end
        wait_drain("the table packets");
        report_test("table traffic with random ready", err0);

        err0 = errors;
        if (stalls_seen == 0) begin
            $display("no valid word was ever stalled, so the hold check never ran");
            errors++;
        end
        if (hold_errors != 0) begin
            $display("t=%0t %0d output values changed while ready was low", $time, hold_errors);
            errors++;
        end
        report_test("outputs hold while ready is low", err0);

        err0 = errors;
        ready_mode = 0;
        repeat (4) @(negedge clk);
        for (int k = 1; k <= `HYDRA_SLOTS; k++) begin
            send_packet(k % 4, (k + 1) % 4, 1, 'h80 + k, 1'b1, ok);
            if (!ok) begin
                $display("t=%0t fill packet %0d was never accepted", $time, k);
                errors++;
            end
            @(negedge clk);
            compare_value("almost_full", almost_full, (`HYDRA_SLOTS - k) < `HYDRA_SLOTS / 2);
            compare_value("full", full, k == `HYDRA_SLOTS);
        end
        send_packet(0, 1, 1, 'h99, 1'b0, ok);
        if (ok) begin
            $display("t=%0t a packet was accepted while every slot was used", $time);
            errors++;
        end
        report_test("buffer fills with ready low", err0);

        err0 = errors;
        ready_mode = 1;
        wait_drain("the stored packets");
        cnt = 0;
        while ((full || almost_full) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (full || almost_full) begin
            $display("t=%0t full or almost_full stayed high after the drain", $time);
            errors++;
        end
        send_packet(0, 1, 1, 'h99, 1'b1, ok);
        if (!ok) begin
            $display("t=%0t the held back packet was not accepted after the drain", $time);
            errors++;
        end
        wait_drain("the held back packet");
        report_test("drain and late packet", err0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== hw/hydra_consts.svh ====
`ifndef HYDRA_CONSTS_SVH
`define HYDRA_CONSTS_SVH

// number of switch ports, each with one input and one output side
`define HYDRA_PORTS 4

// width of one data word on the write and read buses
`define HYDRA_WORD_W 16

// slots in the shared buffer, one packet per slot
`define HYDRA_SLOTS 16

// words per slot, which is also the longest packet the switch takes
`define HYDRA_SLOT_WORDS 16

// low bits of the header word that name the output port
`define HYDRA_DEST_BITS 2

`endif

// ==== hw/hydra_pkg.sv ====
`include "hydra_consts.svh"

package hydra_pkg;

    typedef logic [`HYDRA_WORD_W-1:0] word_t;
    typedef logic [$clog2(`HYDRA_PORTS)-1:0] port_idx_t;
    typedef logic [$clog2(`HYDRA_SLOTS)-1:0] slot_t;
    // slot number in the upper bits, word offset in the lower bits
    typedef logic [$clog2(`HYDRA_SLOTS*`HYDRA_SLOT_WORDS)-1:0] buf_addr_t;
    // one bit wider than the offset so that a full slot can be counted
    typedef logic [$clog2(`HYDRA_SLOT_WORDS):0] pkt_len_t;
    typedef logic [`HYDRA_SLOTS-1:0] slot_mask_t;
    typedef logic [`HYDRA_PORTS-1:0] port_mask_t;

    typedef enum logic [1:0] {
        ING_IDLE,
        ING_GRANT,
        ING_RECV
    } ingress_state_t;

    typedef enum logic [1:0] {
        EG_IDLE,
        EG_SEND,
        EG_DONE
    } egress_state_t;

endpackage

// ==== hw/hydra_switch.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module hydra_switch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  hydra_pkg::port_mask_t wr_sop,
    input  hydra_pkg::port_mask_t wr_eop,
    input  hydra_pkg::port_mask_t wr_vld,
    input  hydra_pkg::word_t      wr_data [`HYDRA_PORTS],
    output hydra_pkg::port_mask_t pause,
    input  hydra_pkg::port_mask_t ready,
    output hydra_pkg::port_mask_t rd_sop,
    output hydra_pkg::port_mask_t rd_eop,
    output hydra_pkg::port_mask_t rd_vld,
    output hydra_pkg::word_t      rd_data [`HYDRA_PORTS],
    output logic                  full,
    output logic                  almost_full
);
    import hydra_pkg::*;

    slot_t      free_slot;
    logic       slot_avail;
    logic       alloc_take;
    logic       buf_wr_en;
    buf_addr_t  buf_wr_addr;
    word_t      buf_wr_data;
    port_mask_t commit_valid;
    slot_t      commit_slot;
    pkt_len_t   commit_len;
    port_mask_t release_valid;
    slot_t      release_slot [`HYDRA_PORTS];
    buf_addr_t  rd_addr [`HYDRA_PORTS];
    word_t      rd_word [`HYDRA_PORTS];

    packet_ingress i_packet_ingress (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_sop       (wr_sop),
        .wr_eop       (wr_eop),
        .wr_vld       (wr_vld),
        .wr_data      (wr_data),
        .pause        (pause),
        .free_slot    (free_slot),
        .slot_avail   (slot_avail),
        .alloc_take   (alloc_take),
        .buf_wr_en    (buf_wr_en),
        .buf_wr_addr  (buf_wr_addr),
        .buf_wr_data  (buf_wr_data),
        .commit_valid (commit_valid),
        .commit_slot  (commit_slot),
        .commit_len   (commit_len)
    );

    slot_allocator i_slot_allocator (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_take    (alloc_take),
        .free_slot     (free_slot),
        .slot_avail    (slot_avail),
        .release_valid (release_valid),
        .release_slot  (release_slot),
        .full          (full),
        .almost_full   (almost_full)
    );

    packet_buffer i_packet_buffer (
        .clk         (clk),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word)
    );

    // one read engine per output port, all sharing the commit bus
    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_egress
        port_egress i_port_egress (
            .clk           (clk),
            .rst_n         (rst_n),
            .commit_valid  (commit_valid[p]),
            .commit_slot   (commit_slot),
            .commit_len    (commit_len),
            .rd_addr       (rd_addr[p]),
            .rd_word       (rd_word[p]),
            .ready         (ready[p]),
            .rd_sop        (rd_sop[p]),
            .rd_eop        (rd_eop[p]),
            .rd_vld        (rd_vld[p]),
            .rd_data       (rd_data[p]),
            .release_valid (release_valid[p]),
            .release_slot  (release_slot[p])
        );
    end

endmodule

// ==== hw/packet_buffer.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module packet_buffer (
    input  logic                 clk,
    input  logic                 buf_wr_en,
    input  hydra_pkg::buf_addr_t buf_wr_addr,
    input  hydra_pkg::word_t     buf_wr_data,
    input  hydra_pkg::buf_addr_t rd_addr [`HYDRA_PORTS],
    output hydra_pkg::word_t     rd_word [`HYDRA_PORTS]
);
    import hydra_pkg::*;

    localparam int DEPTH = `HYDRA_SLOTS * `HYDRA_SLOT_WORDS;

    word_t mem [DEPTH];

    // single writer, since only one ingress packet is in progress at a time
    always_ff @(posedge clk) begin
        if (buf_wr_en) begin
            mem[buf_wr_addr] <= buf_wr_data;
        end
    end

    // each output has its own asynchronous read port
    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_rd
        assign rd_word[p] = mem[rd_addr[p]];
    end

endmodule

// ==== hw/packet_ingress.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module packet_ingress (
    input  logic                  clk,
    input  logic                  rst_n,
    input  hydra_pkg::port_mask_t wr_sop,
    input  hydra_pkg::port_mask_t wr_eop,
    input  hydra_pkg::port_mask_t wr_vld,
    input  hydra_pkg::word_t      wr_data [`HYDRA_PORTS],
    output hydra_pkg::port_mask_t pause,
    input  hydra_pkg::slot_t      free_slot,
    input  logic                  slot_avail,
    output logic                  alloc_take,
    output logic                  buf_wr_en,
    output hydra_pkg::buf_addr_t  buf_wr_addr,
    output hydra_pkg::word_t      buf_wr_data,
    output hydra_pkg::port_mask_t commit_valid,
    output hydra_pkg::slot_t      commit_slot,
    output hydra_pkg::pkt_len_t   commit_len
);
    import hydra_pkg::*;

    localparam int OFS_W = $clog2(`HYDRA_SLOT_WORDS);

    ingress_state_t state;
    port_idx_t      rr_ptr;
    port_idx_t      grant;
    port_idx_t      req_port;
    logic           req_found;
    port_mask_t     req;
    pkt_len_t       word_cnt;
    slot_t          slot_q;
    port_idx_t      dest_q;
    logic           accept;
    logic           first_word;
    slot_t          cur_slot;
    port_idx_t      cur_dest;

    assign req = wr_vld & wr_sop;

    // round robin search starting at the port after the last grant
    always_comb begin
        port_idx_t cand;
        req_found = 1'b0;
        req_port = rr_ptr;
        for (int i = 0; i < `HYDRA_PORTS; i++) begin
            cand = rr_ptr + port_idx_t'(i);
            if (!req_found && req[cand]) begin
                req_found = 1'b1;
                req_port = cand;
            end
        end
    end

    assign accept = (state == ING_RECV) && wr_vld[grant] && !pause[grant];
    assign first_word = (word_cnt == '0);

    // the header word picks the slot and the destination in the same cycle
    assign cur_slot = first_word ? free_slot : slot_q;
    assign cur_dest = first_word ? port_idx_t'(wr_data[grant][`HYDRA_DEST_BITS-1:0]) : dest_q;

    assign alloc_take = accept && first_word;
    assign buf_wr_en = accept;
    assign buf_wr_addr = {cur_slot, word_cnt[OFS_W-1:0]};
    assign buf_wr_data = wr_data[grant];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ING_IDLE;
            rr_ptr <= '0;
            grant <= '0;
            word_cnt <= '0;
            pause <= '1;
            commit_valid <= '0;
        end else begin
            commit_valid <= '0;
            case (state)
                ING_IDLE: begin
                    if (slot_avail && req_found) begin
                        grant <= req_port;
                        rr_ptr <= req_port + 1'b1;
                        state <= ING_GRANT;
                    end
                end
                ING_GRANT: begin
                    pause <= ~(port_mask_t'(1) << grant);
                    word_cnt <= '0;
                    state <= ING_RECV;
                end
                ING_RECV: begin
                    if (accept) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (wr_eop[grant]) begin
                            pause <= '1;
                            word_cnt <= '0;
                            commit_valid <= port_mask_t'(1) << cur_dest;
                            state <= ING_IDLE;
                        end
                    end
                end
                default: state <= ING_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            slot_q <= free_slot;
            dest_q <= cur_dest;
        end
        if (accept && wr_eop[grant]) begin
            commit_slot <= cur_slot;
            commit_len <= word_cnt + 1'b1;
        end
    end

    // a packet that has filled its slot must end on that word
    a_pkt_fits_slot: assert property (@(posedge clk) disable iff (!rst_n)
        accept && (word_cnt == pkt_len_t'(`HYDRA_SLOT_WORDS - 1)) |-> wr_eop[grant]);

endmodule

// ==== hw/port_egress.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module port_egress (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 commit_valid,
    input  hydra_pkg::slot_t     commit_slot,
    input  hydra_pkg::pkt_len_t  commit_len,
    output hydra_pkg::buf_addr_t rd_addr,
    input  hydra_pkg::word_t     rd_word,
    input  logic                 ready,
    output logic                 rd_sop,
    output logic                 rd_eop,
    output logic                 rd_vld,
    output hydra_pkg::word_t     rd_data,
    output logic                 release_valid,
    output hydra_pkg::slot_t     release_slot
);
    import hydra_pkg::*;

    localparam int OFS_W = $clog2(`HYDRA_SLOT_WORDS);
    localparam int CNT_W = $clog2(`HYDRA_SLOTS) + 1;

    // one entry per buffer slot, so every committed packet always fits
    slot_t            fifo_slot [`HYDRA_SLOTS];
    pkt_len_t         fifo_len [`HYDRA_SLOTS];
    slot_t            wr_ptr;
    slot_t            rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;

    egress_state_t state;
    slot_t         cur_slot;
    pkt_len_t      cur_len;
    pkt_len_t      ofs;
    slot_t         head_slot;
    pkt_len_t      head_len;
    logic          pop;
    logic          load;
    logic          last;
    logic          eop_moved;

    assign head_slot = fifo_slot[rd_ptr];
    assign head_len = fifo_len[rd_ptr];

    // the output register only advances while the sink is ready
    assign pop = ready && (state == EG_IDLE) && (fifo_cnt != '0);
    assign load = pop || (ready && (state == EG_SEND));
    assign eop_moved = (state == EG_DONE) && ready && rd_vld && rd_eop;

    // word 0 of the head packet is read straight from the FIFO entry
    assign rd_addr = (state == EG_IDLE) ? {head_slot, {OFS_W{1'b0}}}
                                        : {cur_slot, ofs[OFS_W-1:0]};
    assign last = (state == EG_IDLE) ? (head_len == pkt_len_t'(1))
                                     : (ofs == cur_len - 1'b1);

    always_ff @(posedge clk) begin
        if (commit_valid) begin
            fifo_slot[wr_ptr] <= commit_slot;
            fifo_len[wr_ptr] <= commit_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
        end else begin
            if (commit_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CNT_W'(commit_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EG_IDLE;
            ofs <= '0;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            release_valid <= 1'b0;
        end else begin
            release_valid <= 1'b0;
            if (ready) begin
                rd_vld <= load;
                rd_sop <= pop;
                rd_eop <= load && last;
            end
            case (state)
                EG_IDLE: begin
                    if (pop) begin
                        ofs <= pkt_len_t'(1);
                        state <= last ? EG_DONE : EG_SEND;
                    end
                end
                EG_SEND: begin
                    if (load) begin
                        ofs <= ofs + 1'b1;
                        if (last) begin
                            state <= EG_DONE;
                        end
                    end
                end
                EG_DONE: begin
                    // the slot is handed back once the sink has taken the eop word
                    if (eop_moved) begin
                        release_valid <= 1'b1;
                        state <= EG_IDLE;
                    end
                end
                default: state <= EG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_slot <= head_slot;
            cur_len <= head_len;
        end
        if (load) begin
            rd_data <= rd_word;
        end
    end

    // cur_slot is only replaced by the next pop, which comes no earlier than the release
    assign release_slot = cur_slot;

    // the allocator bounds the packets in flight, so the queue has room for every commit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> fifo_cnt < CNT_W'(`HYDRA_SLOTS));

endmodule

// ==== hw/slot_allocator.sv ====
`timescale 1ns/1ps
`include "hydra_consts.svh"

module slot_allocator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_take,
    output hydra_pkg::slot_t      free_slot,
    output logic                  slot_avail,
    input  hydra_pkg::port_mask_t release_valid,
    input  hydra_pkg::slot_t      release_slot [`HYDRA_PORTS],
    output logic                  full,
    output logic                  almost_full
);
    import hydra_pkg::*;

    localparam int CNT_W = $clog2(`HYDRA_SLOTS) + 1;

    slot_mask_t       used;
    slot_mask_t       used_next;
    logic [CNT_W-1:0] free_cnt;

    // priority encoder, the scan runs downward so the lowest free slot wins
    always_comb begin
        free_slot = '0;
        slot_avail = 1'b0;
        for (int s = `HYDRA_SLOTS - 1; s >= 0; s--) begin
            if (!used[s]) begin
                free_slot = slot_t'(s);
                slot_avail = 1'b1;
            end
        end
    end

    always_comb begin
        used_next = used;
        if (alloc_take) begin
            used_next[free_slot] = 1'b1;
        end
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            if (release_valid[p]) begin
                used_next[release_slot[p]] = 1'b0;
            end
        end
    end

    assign free_cnt = CNT_W'($countones(~used));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            used <= '0;
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            used <= used_next;
            // flags follow the bitmap one cycle late
            full <= (free_cnt == '0);
            almost_full <= (free_cnt < CNT_W'(`HYDRA_SLOTS / 2));
        end
    end

    // an egress may only hand back a slot that ingress actually took
    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_release_chk
        a_release_used: assert property (@(posedge clk) disable iff (!rst_n)
            release_valid[p] |-> used[release_slot[p]]);
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the switch testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module hydra_tb \
    -Mdir obj_dir -o hydra_sim \
    && ./obj_dir/hydra_sim | tee sim.log \
    && grep -q '\*\* PASS \*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+hw
+incdir+bench
hw/hydra_pkg.sv
hw/packet_ingress.sv
hw/slot_allocator.sv
hw/packet_buffer.sv
hw/port_egress.sv
hw/hydra_switch.sv
bench/hydra_tb.sv
